// ==== common/mem_pkg.sv ====
// Widths assume a 64-bit word-aligned SRAM; address bits below WORD_LSB are ignored everywhere
`default_nettype none

package mem_pkg;

  // ------------------------------------------------
  // Bus widths
  // ------------------------------------------------
  localparam int DATA_W = 64;
  localparam int ADDR_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STRB_W-1:0] strb_t;

  // ------------------------------------------------
  // SRAM geometry
  // ------------------------------------------------
  localparam int MEM_WORDS  = 1024;
  localparam int WORD_IDX_W = $clog2(MEM_WORDS);
  // Byte offset bits inside one word
  localparam int WORD_LSB   = $clog2(STRB_W);

  // First byte address past the end of the SRAM
  localparam addr_t MEM_BYTES = addr_t'(MEM_WORDS * STRB_W);

  typedef logic [WORD_IDX_W-1:0] word_idx_t;

  // AXI-lite response codes
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // ------------------------------------------------
  // FSM encodings
  // ------------------------------------------------
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_READ,
    ARB_WRITE
  } arb_state_t;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

endpackage

`default_nettype wire

// ==== common/axil_if.sv ====
// AXI-lite without prot, single outstanding transaction per channel pair, no IDs or bursts
`default_nettype none

interface axil_if import mem_pkg::*; ();

  // Write address channel
  logic  awvalid;
  logic  awready;
  addr_t awaddr;

  // Write data channel
  logic  wvalid;
  logic  wready;
  data_t wdata;
  strb_t wstrb;

  // Write response channel
  logic  bvalid;
  logic  bready;
  resp_t bresp;

  // Read address channel
  logic  arvalid;
  logic  arready;
  addr_t araddr;

  // Read data channel
  logic  rvalid;
  logic  rready;
  data_t rdata;
  resp_t rresp;

  modport mgr (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready,
    output arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp,
    input  arready, rvalid, rdata, rresp
  );

  modport sub (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
    input  arvalid, araddr, rready,
    output awready, wready, bvalid, bresp,
    output arready, rvalid, rdata, rresp
  );

endinterface

`default_nettype wire

// ==== axil_arbiter/axil_arbiter.sv ====
// Grants one whole read or write at a time; round-robin on contention, read before write per manager
`default_nettype none

module axil_arbiter import mem_pkg::*; (
  input  logic i_aclk,
  input  logic i_rst,
  axil_if.sub  i_m0,
  axil_if.sub  i_m1,
  axil_if.mgr  o_s
);

  arb_state_t state_q;
  arb_state_t state_d;
  logic       gnt_q;    // manager that owns the bus
  logic       gnt_d;
  logic       last_q;   // manager that finished last

  logic req_m0;
  logic req_m1;
  logic win_rd;
  logic sel_rd;
  logic sel_wr;
  logic r_fire;
  logic b_fire;

  // Per-manager channel enables
  logic m0_rd;
  logic m0_wr;
  logic m1_rd;
  logic m1_wr;

  assign req_m0 = i_m0.arvalid | i_m0.awvalid;
  assign req_m1 = i_m1.arvalid | i_m1.awvalid;

  assign r_fire = o_s.rvalid & o_s.rready;
  assign b_fire = o_s.bvalid & o_s.bready;

  // ------------------------------------------------
  // Grant FSM
  // ------------------------------------------------
  always_comb begin
    state_d = state_q;
    gnt_d   = gnt_q;
    win_rd  = 1'b0;
    case (state_q)
      ARB_IDLE: begin
        if (req_m0 && req_m1) begin
          gnt_d = ~last_q;
        end else begin
          gnt_d = req_m1;
        end
        // Reads of the winner go first
        win_rd = gnt_d ? i_m1.arvalid : i_m0.arvalid;
        if (req_m0 || req_m1) begin
          state_d = win_rd ? ARB_READ : ARB_WRITE;
        end
      end
      ARB_READ: begin
        if (r_fire) begin
          state_d = ARB_IDLE;
        end
      end
      ARB_WRITE: begin
        if (b_fire) begin
          state_d = ARB_IDLE;
        end
      end
      default: state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state_q <= ARB_IDLE;
      gnt_q   <= 1'b0;
      last_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      gnt_q   <= gnt_d;
      if (state_q != ARB_IDLE && state_d == ARB_IDLE) begin
        last_q <= gnt_q;
      end
    end
  end

  // ------------------------------------------------
  // Channel muxing
  // ------------------------------------------------
  assign sel_rd = (state_q == ARB_READ);
  assign sel_wr = (state_q == ARB_WRITE);

  assign m0_rd = sel_rd & ~gnt_q;
  assign m0_wr = sel_wr & ~gnt_q;
  assign m1_rd = sel_rd & gnt_q;
  assign m1_wr = sel_wr & gnt_q;

  // Only the active direction reaches the SRAM
  assign o_s.arvalid = sel_rd & (gnt_q ? i_m1.arvalid : i_m0.arvalid);
  assign o_s.araddr  = gnt_q ? i_m1.araddr : i_m0.araddr;
  assign o_s.rready  = sel_rd & (gnt_q ? i_m1.rready : i_m0.rready);
  assign o_s.awvalid = sel_wr & (gnt_q ? i_m1.awvalid : i_m0.awvalid);
  assign o_s.awaddr  = gnt_q ? i_m1.awaddr : i_m0.awaddr;
  assign o_s.wvalid  = sel_wr & (gnt_q ? i_m1.wvalid : i_m0.wvalid);
  assign o_s.wdata   = gnt_q ? i_m1.wdata : i_m0.wdata;
  assign o_s.wstrb   = gnt_q ? i_m1.wstrb : i_m0.wstrb;
  assign o_s.bready  = sel_wr & (gnt_q ? i_m1.bready : i_m0.bready);

  // Manager 0 return path
  assign i_m0.arready = m0_rd & o_s.arready;
  assign i_m0.rvalid  = m0_rd & o_s.rvalid;
  assign i_m0.rdata   = o_s.rdata;
  assign i_m0.rresp   = o_s.rresp;
  assign i_m0.awready = m0_wr & o_s.awready;
  assign i_m0.wready  = m0_wr & o_s.wready;
  assign i_m0.bvalid  = m0_wr & o_s.bvalid;
  assign i_m0.bresp   = o_s.bresp;

  // Manager 1 return path
  assign i_m1.arready = m1_rd & o_s.arready;
  assign i_m1.rvalid  = m1_rd & o_s.rvalid;
  assign i_m1.rdata   = o_s.rdata;
  assign i_m1.rresp   = o_s.rresp;
  assign i_m1.awready = m1_wr & o_s.awready;
  assign i_m1.wready  = m1_wr & o_s.wready;
  assign i_m1.bvalid  = m1_wr & o_s.bvalid;
  assign i_m1.bresp   = o_s.bresp;

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  // A blocked manager never gets a handshake
  a_blocked_ready: assert property (@(posedge i_aclk) disable iff (i_rst)
    !((!(m0_rd | m0_wr) && (i_m0.arready | i_m0.awready | i_m0.wready)) ||
      (!(m1_rd | m1_wr) && (i_m1.arready | i_m1.awready | i_m1.wready))));

  // Read and write never share the SRAM bus
  a_one_dir: assert property (@(posedge i_aclk) disable iff (i_rst)
    !((o_s.arvalid | o_s.rready) && (o_s.awvalid | o_s.wvalid | o_s.bready)));

endmodule

`default_nettype wire

// ==== sram_wrap/axil_sram_wrap.sv ====
// Word-addressed SRAM behind AXI-lite; addresses at or above MEM_BYTES return SLVERR, no storage reset
`default_nettype none

module axil_sram_wrap import mem_pkg::*; (
  input  logic i_aclk,
  input  logic i_rst,
  axil_if.sub  i_s
);

  rd_state_t rd_state_q;
  wr_state_t wr_state_q;

  data_t mem [MEM_WORDS];

  // Read payload, held until the r transfer
  data_t rdata_q;
  resp_t rresp_q;

  // Write address from the aw transfer
  addr_t wr_addr_q;

  logic ar_fire;
  logic r_fire;
  logic aw_fire;
  logic w_fire;
  logic b_fire;

  logic      rd_in_range;
  logic      wr_in_range;
  word_idx_t rd_idx;
  word_idx_t wr_idx;

  assign ar_fire = i_s.arvalid & i_s.arready;
  assign r_fire  = i_s.rvalid  & i_s.rready;
  assign aw_fire = i_s.awvalid & i_s.awready;
  assign w_fire  = i_s.wvalid  & i_s.wready;
  assign b_fire  = i_s.bvalid  & i_s.bready;

  assign rd_in_range = (i_s.araddr < MEM_BYTES);
  assign wr_in_range = (wr_addr_q < MEM_BYTES);
  assign rd_idx      = i_s.araddr[WORD_LSB +: WORD_IDX_W];
  assign wr_idx      = wr_addr_q[WORD_LSB +: WORD_IDX_W];

  // ------------------------------------------------
  // Read side
  // ------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      rd_state_q <= RD_IDLE;
    end else begin
      case (rd_state_q)
        RD_IDLE: if (ar_fire) rd_state_q <= RD_DATA;
        RD_DATA: if (r_fire) rd_state_q <= RD_IDLE;
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rdata_q <= rd_in_range ? mem[rd_idx] : '0;
      rresp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign i_s.arready = (rd_state_q == RD_IDLE);
  assign i_s.rvalid  = (rd_state_q == RD_DATA);
  assign i_s.rdata   = rdata_q;
  assign i_s.rresp   = rresp_q;

  // ------------------------------------------------
  // Write side
  // ------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_state_q <= WR_IDLE;
    end else begin
      case (wr_state_q)
        WR_IDLE: if (aw_fire) wr_state_q <= WR_DATA;
        WR_DATA: if (w_fire) wr_state_q <= WR_RESP;
        WR_RESP: if (b_fire) wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      wr_addr_q <= i_s.awaddr;
    end
  end

  // Commit on the data beat, strobed bytes only
  always_ff @(posedge i_aclk) begin
    if (w_fire && wr_in_range) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_s.wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= i_s.wdata[8*b +: 8];
        end
      end
    end
  end

  assign i_s.awready = (wr_state_q == WR_IDLE);
  assign i_s.wready  = (wr_state_q == WR_DATA);
  assign i_s.bvalid  = (wr_state_q == WR_RESP);
  // wr_addr_q is stable through WR_RESP
  assign i_s.bresp   = wr_in_range ? RESP_OKAY : RESP_SLVERR;

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  a_r_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    (i_s.rvalid && !i_s.rready) |=> (i_s.rvalid && $stable(i_s.rdata) && $stable(i_s.rresp)));

  a_b_after_w: assert property (@(posedge i_aclk) disable iff (i_rst)
    $rose(i_s.bvalid) |-> $past(w_fire));

endmodule

`default_nettype wire

// ==== design/mem_subsys_top.sv ====
// Two AXI-lite managers share one SRAM; each port sees ready low until the arbiter grants it
`default_nettype none

module mem_subsys_top import mem_pkg::*; (
  input  logic  i_aclk,
  input  logic  i_rst,

  // Manager 0, load/store unit
  input  logic  i_m0_awvalid,
  input  addr_t i_m0_awaddr,
  input  logic  i_m0_wvalid,
  input  data_t i_m0_wdata,
  input  strb_t i_m0_wstrb,
  input  logic  i_m0_bready,
  input  logic  i_m0_arvalid,
  input  addr_t i_m0_araddr,
  input  logic  i_m0_rready,
  output logic  o_m0_awready,
  output logic  o_m0_wready,
  output logic  o_m0_bvalid,
  output resp_t o_m0_bresp,
  output logic  o_m0_arready,
  output logic  o_m0_rvalid,
  output data_t o_m0_rdata,
  output resp_t o_m0_rresp,

  // Manager 1, DMA
  input  logic  i_m1_awvalid,
  input  addr_t i_m1_awaddr,
  input  logic  i_m1_wvalid,
  input  data_t i_m1_wdata,
  input  strb_t i_m1_wstrb,
  input  logic  i_m1_bready,
  input  logic  i_m1_arvalid,
  input  addr_t i_m1_araddr,
  input  logic  i_m1_rready,
  output logic  o_m1_awready,
  output logic  o_m1_wready,
  output logic  o_m1_bvalid,
  output resp_t o_m1_bresp,
  output logic  o_m1_arready,
  output logic  o_m1_rvalid,
  output data_t o_m1_rdata,
  output resp_t o_m1_rresp
);

  axil_if m0_bus ();
  axil_if m1_bus ();
  axil_if s_bus ();

  // ------------------------------------------------
  // Port mapping
  // ------------------------------------------------
  assign m0_bus.awvalid = i_m0_awvalid;
  assign m0_bus.awaddr  = i_m0_awaddr;
  assign m0_bus.wvalid  = i_m0_wvalid;
  assign m0_bus.wdata   = i_m0_wdata;
  assign m0_bus.wstrb   = i_m0_wstrb;
  assign m0_bus.bready  = i_m0_bready;
  assign m0_bus.arvalid = i_m0_arvalid;
  assign m0_bus.araddr  = i_m0_araddr;
  assign m0_bus.rready  = i_m0_rready;
  assign o_m0_awready   = m0_bus.awready;
  assign o_m0_wready    = m0_bus.wready;
  assign o_m0_bvalid    = m0_bus.bvalid;
  assign o_m0_bresp     = m0_bus.bresp;
  assign o_m0_arready   = m0_bus.arready;
  assign o_m0_rvalid    = m0_bus.rvalid;
  assign o_m0_rdata     = m0_bus.rdata;
  assign o_m0_rresp     = m0_bus.rresp;

  assign m1_bus.awvalid = i_m1_awvalid;
  assign m1_bus.awaddr  = i_m1_awaddr;
  assign m1_bus.wvalid  = i_m1_wvalid;
  assign m1_bus.wdata   = i_m1_wdata;
  assign m1_bus.wstrb   = i_m1_wstrb;
  assign m1_bus.bready  = i_m1_bready;
  assign m1_bus.arvalid = i_m1_arvalid;
  assign m1_bus.araddr  = i_m1_araddr;
  assign m1_bus.rready  = i_m1_rready;
  assign o_m1_awready   = m1_bus.awready;
  assign o_m1_wready    = m1_bus.wready;
  assign o_m1_bvalid    = m1_bus.bvalid;
  assign o_m1_bresp     = m1_bus.bresp;
  assign o_m1_arready   = m1_bus.arready;
  assign o_m1_rvalid    = m1_bus.rvalid;
  assign o_m1_rdata     = m1_bus.rdata;
  assign o_m1_rresp     = m1_bus.rresp;

  axil_arbiter u_arbiter (
    .i_aclk (i_aclk),
    .i_rst  (i_rst),
    .i_m0   (m0_bus.sub),
    .i_m1   (m1_bus.sub),
    .o_s    (s_bus.mgr)
  );

  axil_sram_wrap u_sram (
    .i_aclk (i_aclk),
    .i_rst  (i_rst),
    .i_s    (s_bus.sub)
  );

endmodule

`default_nettype wire

// ==== tb/tb_mem_subsys.sv ====
// SRAM has no reset, so reads only target words written earlier; contention keeps managers in separate halves
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

  logic aclk;
  logic rst;

  // Manager-side signals, index 0 is the load/store unit and 1 the DMA
  logic  awvalid [2];
  addr_t awaddr  [2];
  logic  wvalid  [2];
  data_t wdata   [2];
  strb_t wstrb   [2];
  logic  bready  [2];
  logic  arvalid [2];
  addr_t araddr  [2];
  logic  rready  [2];
  logic  awready [2];
  logic  wready  [2];
  logic  bvalid  [2];
  resp_t bresp   [2];
  logic  arready [2];
  logic  rvalid  [2];
  data_t rdata   [2];
  resp_t rresp   [2];
  logic  port_busy [2];

  // Predicted responses per manager
  data_t exp_rdata [2];
  resp_t exp_rresp [2];
  resp_t exp_bresp [2];

  data_t  shadow [MEM_WORDS];
  addr_t  known [2][16];
  int     done_log [$];
  integer seed;
  string  test_name;
  logic   idle_chk;
  logic   alt_chk;
  int     fails;
  int     fails_at_start;
  int     ntests;
  int     nfailed;

  mem_subsys_top dut (
    .i_aclk       (aclk),
    .i_rst        (rst),
    .i_m0_awvalid (awvalid[0]),
    .i_m0_awaddr  (awaddr[0]),
    .i_m0_wvalid  (wvalid[0]),
    .i_m0_wdata   (wdata[0]),
    .i_m0_wstrb   (wstrb[0]),
    .i_m0_bready  (bready[0]),
    .i_m0_arvalid (arvalid[0]),
    .i_m0_araddr  (araddr[0]),
    .i_m0_rready  (rready[0]),
    .o_m0_awready (awready[0]),
    .o_m0_wready  (wready[0]),
    .o_m0_bvalid  (bvalid[0]),
    .o_m0_bresp   (bresp[0]),
    .o_m0_arready (arready[0]),
    .o_m0_rvalid  (rvalid[0]),
    .o_m0_rdata   (rdata[0]),
    .o_m0_rresp   (rresp[0]),
    .i_m1_awvalid (awvalid[1]),
    .i_m1_awaddr  (awaddr[1]),
    .i_m1_wvalid  (wvalid[1]),
    .i_m1_wdata   (wdata[1]),
    .i_m1_wstrb   (wstrb[1]),
    .i_m1_bready  (bready[1]),
    .i_m1_arvalid (arvalid[1]),
    .i_m1_araddr  (araddr[1]),
    .i_m1_rready  (rready[1]),
    .o_m1_awready (awready[1]),
    .o_m1_wready  (wready[1]),
    .o_m1_bvalid  (bvalid[1]),
    .o_m1_bresp   (bresp[1]),
    .o_m1_arready (arready[1]),
    .o_m1_rvalid  (rvalid[1]),
    .o_m1_rdata   (rdata[1]),
    .o_m1_rresp   (rresp[1])
  );

  always #5 aclk = ~aclk;

  // ------------------------------------------------
  // Checks, sampled on the falling edge
  // ------------------------------------------------
  for (genvar g = 0; g < 2; g++) begin : g_check
    assign port_busy[g] = awready[g] | wready[g] | bvalid[g] | arready[g] | rvalid[g];

    a_rdata: assert property (@(negedge aclk) disable iff (rst)
      (rvalid[g] && rready[g]) |-> (rdata[g] == exp_rdata[g] && rresp[g] == exp_rresp[g]))
      else begin
        $display("Mismatch: test %s, manager %0d read, expected resp %0d data %h, actual resp %0d data %h",
                 test_name, g, exp_rresp[g], exp_rdata[g], rresp[g], rdata[g]);
        fails++;
      end

    a_bresp: assert property (@(negedge aclk) disable iff (rst)
      (bvalid[g] && bready[g]) |-> (bresp[g] == exp_bresp[g]))
      else begin
        $display("Mismatch: test %s, manager %0d write, expected resp %0d, actual resp %0d",
                 test_name, g, exp_bresp[g], bresp[g]);
        fails++;
      end

    a_rhold: assert property (@(negedge aclk) disable iff (rst)
      (rvalid[g] && !rready[g]) |=> (rvalid[g] && $stable(rdata[g]) && $stable(rresp[g])))
      else begin
        $display("Error: test %s, manager %0d read data dropped or changed while stalled",
                 test_name, g);
        fails++;
      end
  end

  a_idle: assert property (@(negedge aclk) idle_chk |-> !(port_busy[0] || port_busy[1]))
    else begin
      $display("Error: test %s, a valid or ready output was high around reset", test_name);
      fails++;
    end

  // Completion order, one entry per r or b transfer
  always @(negedge aclk) begin
    if (!rst) begin
      for (int m = 0; m < 2; m++) begin
        if ((rvalid[m] && rready[m]) || (bvalid[m] && bready[m])) begin
          if (alt_chk && done_log.size() > 0) begin
            assert (done_log[$] != m) else begin
              $display("Error: test %s, manager %0d was granted twice in a row under contention",
                       test_name, m);
              fails++;
            end
          end
          done_log.push_back(m);
        end
      end
    end
  end

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  function automatic data_t rand_data();
    data_t d;
    d[63:32] = $random(seed);
    d[31:0]  = $random(seed);
    return d;
  endfunction

  // Byte address of a word, with junk in the ignored low bits
  function automatic addr_t word_addr(input int idx);
    return (addr_t'(idx) << WORD_LSB) | addr_t'($random(seed) & 7);
  endfunction

  function automatic data_t merge_bytes(input data_t old_d, input data_t new_d, input strb_t strb);
    data_t d;
    d = old_d;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        d[8*b +: 8] = new_d[8*b +: 8];
      end
    end
    return d;
  endfunction

  function automatic logic chan_up(input int m, input string ch);
    case (ch)
      "ar":    return arvalid[m] && arready[m];
      "r":     return rvalid[m] && rready[m];
      "aw":    return awvalid[m] && awready[m];
      "w":     return wvalid[m] && wready[m];
      default: return bvalid[m] && bready[m];
    endcase
  endfunction

  // Returns on the edge that completes the handshake
  task automatic wait_handshake(input int m, input string ch, input bit stall);
    int cycles;
    cycles = 0;
    @(negedge aclk);
    while (!chan_up(m, ch) && cycles < 200) begin
      @(posedge aclk);
      if (stall && ch == "r") begin
        rready[m] <= (($random(seed) & 3) == 0);
      end
      @(negedge aclk);
      cycles++;
    end
    if (!chan_up(m, ch)) begin
      $display("Timeout: test %s, manager %0d waited 200 cycles for the %s handshake",
               test_name, m, ch);
      fails++;
    end
    @(posedge aclk);
  endtask

  // Bus tasks start on the caller's rising edge, so a follow-up request
  // is already up when the previous grant ends
  task automatic axil_write(input int m, input addr_t addr, input data_t data, input strb_t strb);
    awvalid[m] <= 1'b1;
    awaddr[m]  <= addr;
    wvalid[m]  <= 1'b1;
    wdata[m]   <= data;
    wstrb[m]   <= strb;
    bready[m]  <= 1'b1;
    exp_bresp[m] = (addr < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
    wait_handshake(m, "aw", 1'b0);
    awvalid[m] <= 1'b0;
    wait_handshake(m, "w", 1'b0);
    wvalid[m] <= 1'b0;
    wait_handshake(m, "b", 1'b0);
    bready[m] <= 1'b0;
    if (addr < MEM_BYTES) begin
      shadow[addr[WORD_LSB +: WORD_IDX_W]] =
        merge_bytes(shadow[addr[WORD_LSB +: WORD_IDX_W]], data, strb);
    end
  endtask

  task automatic axil_read(input int m, input addr_t addr, input bit stall);
    arvalid[m] <= 1'b1;
    araddr[m]  <= addr;
    rready[m]  <= !stall;
    exp_rdata[m] = (addr < MEM_BYTES) ? shadow[addr[WORD_LSB +: WORD_IDX_W]] : '0;
    exp_rresp[m] = (addr < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
    wait_handshake(m, "ar", 1'b0);
    arvalid[m] <= 1'b0;
    wait_handshake(m, "r", stall);
    rready[m] <= 1'b0;
  endtask

  // Write then read back, inside this manager's half of the SRAM
  task automatic run_traffic(input int m);
    addr_t a;
    for (int i = 0; i < 10; i++) begin
      a = word_addr(m * 512 + ($random(seed) & 511));
      axil_write(m, a, rand_data(), '1);
      axil_read(m, a, 1'b0);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    fails_at_start = fails;
  endtask

  task automatic end_test();
    ntests++;
    if (fails == fails_at_start) begin
      $display("Test %-12s PASS", test_name);
    end else begin
      nfailed++;
      $display("Test %-12s FAIL, %0d errors", test_name, fails - fails_at_start);
    end
  endtask

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin
    seed     = 51793;
    aclk     = 1'b0;
    rst      = 1'b1;
    idle_chk = 1'b0;
    alt_chk  = 1'b0;
    fails    = 0;
    ntests   = 0;
    nfailed  = 0;
    for (int m = 0; m < 2; m++) begin
      awvalid[m] = 1'b0;
      awaddr[m]  = '0;
      wvalid[m]  = 1'b0;
      wdata[m]   = '0;
      wstrb[m]   = '0;
      bready[m]  = 1'b0;
      arvalid[m] = 1'b0;
      araddr[m]  = '0;
      rready[m]  = 1'b0;
    end

    begin_test("reset");
    repeat (2) @(posedge aclk);
    idle_chk <= 1'b1;
    repeat (3) @(posedge aclk);
    rst <= 1'b0;
    repeat (5) @(posedge aclk);
    idle_chk <= 1'b0;
    end_test();

    begin_test("write_read");
    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < 16; i++) begin
        known[m][i] = word_addr($random(seed) & 1023);
        axil_write(m, known[m][i], rand_data(), '1);
      end
      for (int i = 0; i < 16; i++) begin
        axil_read(m, known[m][i], 1'b0);
      end
    end
    end_test();

    begin_test("strobes");
    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < 8; i++) begin
        axil_write(m, known[m][i], rand_data(), strb_t'($random(seed)));
        axil_read(m, known[m][i], 1'b0);
      end
    end
    end_test();

    begin_test("range");
    for (int m = 0; m < 2; m++) begin
      axil_read(m, MEM_BYTES, 1'b0);
      axil_read(m, addr_t'(32'hffff_fff8), 1'b0);
      // Same word index as a live word, one SRAM size higher
      axil_write(m, MEM_BYTES + known[m][0], rand_data(), '1);
      axil_read(m, known[m][0], 1'b0);
    end
    end_test();

    begin_test("contention");
    done_log.delete();
    alt_chk = 1'b1;
    fork
      run_traffic(0);
      run_traffic(1);
    join
    alt_chk = 1'b0;
    assert (done_log.size() == 40) else begin
      $display("Error: test %s, only %0d of 40 transactions completed", test_name, done_log.size());
      fails++;
    end
    end_test();

    begin_test("backpressure");
    for (int r = 0; r < 4; r++) begin
      done_log.delete();
      fork
        axil_read(0, known[0][r], 1'b1);
        begin
          @(posedge aclk);
          axil_write(1, known[1][r], rand_data(), '1);
        end
      join
      assert (done_log.size() == 2 && done_log[0] == 0 && done_log[1] == 1) else begin
        $display("Error: test %s, the write finished before the stalled read", test_name);
        fails++;
      end
    end
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d errors", ntests, nfailed, fails);
    if (fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_subsys.f ====
common/mem_pkg.sv
common/axil_if.sv
axil_arbiter/axil_arbiter.sv
sram_wrap/axil_sram_wrap.sv
design/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator simulation of the shared-SRAM memory subsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --top-module tb_mem_subsys -f mem_subsys.f -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir
